// ==== src/serial_link_pkg.sv ====
/*
 * Shared sizes, timing constants, control register fields and state
 * encodings for the serial link wrapper. Blocks reach everything here
 * through scoped names. The LFSR step is shared by the frame generator
 * and the frame checker.
 */
package serial_link_pkg;

    // Word and register widths
    localparam int DATA_W = 16;
    localparam int CTRL_W = 11;
    localparam int CNT_W  = 16;
    localparam int STAT_W = 3;

    // Control register fields, upper bits ignored
    localparam int CTRL_RESET_BIT = 0;
    localparam int CTRL_TEST_BIT  = 1;
    localparam int CTRL_LOOP_LO   = 2;
    localparam int CTRL_PDOWN_BIT = 4;

    // Timing in USER_CLK cycles
    localparam int RESET_STRETCH    = 30;
    localparam int LANE_INIT_CYCLES = 8;
    localparam int LINK_LATENCY     = 4;
    localparam int CC_PERIOD        = 64;
    localparam int CC_LENGTH        = 2;

    // Test frames
    localparam int                FRAME_WORDS = 8;
    localparam logic [DATA_W-1:0] LFSR_SEED   = 16'hACE1;

    // Counter widths
    localparam int FRAME_CNT_W = $clog2(FRAME_WORDS);
    localparam int INIT_CNT_W  = $clog2(LANE_INIT_CYCLES);
    localparam int CC_CNT_W    = $clog2(CC_PERIOD);

    typedef enum logic [1:0] {LOOP_NONE, LOOP_NEAR, LOOP_FAR, LOOP_SERIAL} loop_mode_e;
    typedef enum logic [1:0] {LANE_DOWN, LANE_INIT, LANE_UP, CHANNEL_UP} lane_state_e;
    typedef enum logic {GEN_IDLE, GEN_FRAME} gen_state_e;

    // Fibonacci step, taps 16 14 13 11
    function automatic logic [DATA_W-1:0] lfsr_next(input logic [DATA_W-1:0] cur);
        logic fb;
        fb = cur[15] ^ cur[13] ^ cur[12] ^ cur[10];
        return {cur[DATA_W-2:0], fb};
    endfunction

endpackage

// ==== src/link_ctrl_decode.sv ====
/*
 * Control register decode. Stretches RESET_IN into the lane reset,
 * registers the control fields and picks the transmit source:
 * user words in normal mode, generator words in test mode.
 */
`timescale 1ns/1ps

module link_ctrl_decode (
    input  logic                                USER_CLK,
    input  logic                                RESET_IN,
    input  logic [serial_link_pkg::CTRL_W-1:0]  ctrl_reg_i,
    input  logic                                lane_up_i,
    input  logic [serial_link_pkg::DATA_W-1:0]  user_data_i,
    input  logic                                user_valid_i,
    input  logic                                user_sof_i,
    input  logic                                user_eof_i,
    input  logic [serial_link_pkg::DATA_W-1:0]  gen_data_i,
    input  logic                                gen_valid_i,
    input  logic                                gen_sof_i,
    input  logic                                gen_eof_i,
    output logic                                core_reset_o,
    output logic                                test_reset_o,
    output logic                                test_mode_o,
    output logic                                power_down_o,
    output serial_link_pkg::loop_mode_e         loop_mode_o,
    output logic [serial_link_pkg::DATA_W-1:0]  tx_data_o,
    output logic                                tx_valid_o,
    output logic                                tx_sof_o,
    output logic                                tx_eof_o
);

    logic [serial_link_pkg::RESET_STRETCH-1:0]  stretch;
    logic [serial_link_pkg::CTRL_PDOWN_BIT:0]   ctrl_q;

    // Reset stretcher, all ones while RESET_IN, then drains
    always_ff @(posedge USER_CLK) begin
        if (RESET_IN) begin
            stretch <= '1;
            ctrl_q  <= '0;
        end else begin
            stretch <= {stretch[serial_link_pkg::RESET_STRETCH-2:0], 1'b0};
            ctrl_q  <= ctrl_reg_i[serial_link_pkg::CTRL_PDOWN_BIT:0];
        end
    end

    // Control fields
    assign core_reset_o = stretch[serial_link_pkg::RESET_STRETCH-1] |
                          ctrl_q[serial_link_pkg::CTRL_RESET_BIT];
    assign test_mode_o  = ctrl_q[serial_link_pkg::CTRL_TEST_BIT];
    assign power_down_o = ctrl_q[serial_link_pkg::CTRL_PDOWN_BIT];
    assign loop_mode_o  = serial_link_pkg::loop_mode_e'(
                          ctrl_q[serial_link_pkg::CTRL_LOOP_LO +: 2]);

    // Generator and checker idle unless testing on a live lane
    assign test_reset_o = !test_mode_o || !lane_up_i;

    // Transmit source select
    assign tx_data_o  = test_mode_o ? gen_data_i  : user_data_i;
    assign tx_valid_o = test_mode_o ? gen_valid_i : user_valid_i;
    assign tx_sof_o   = test_mode_o ? gen_sof_i   : user_sof_i;
    assign tx_eof_o   = test_mode_o ? gen_eof_i   : user_eof_i;

    // Lane stays in reset for the whole stretch window
    a_reset_stretch : assert property (@(posedge USER_CLK)
        RESET_IN |=> core_reset_o [*serial_link_pkg::RESET_STRETCH]);

endmodule

// ==== src/frame_gen.sv ====
/*
 * Test frame generator. Sends back-to-back frames of FRAME_WORDS
 * pseudo-random words while the test reset is low. The LFSR steps
 * once per accepted word, so the checker can predict every word.
 */
`timescale 1ns/1ps

module frame_gen (
    input  logic                                USER_CLK,
    input  logic                                test_reset_i,
    input  logic                                ready_i,
    output logic [serial_link_pkg::DATA_W-1:0]  data_o,
    output logic                                valid_o,
    output logic                                sof_o,
    output logic                                eof_o
);

    serial_link_pkg::gen_state_e                state;
    logic [serial_link_pkg::FRAME_CNT_W-1:0]    word_cnt;
    logic [serial_link_pkg::DATA_W-1:0]         lfsr;
    logic                                       last_word;

    assign last_word = word_cnt ==
                       serial_link_pkg::FRAME_CNT_W'(serial_link_pkg::FRAME_WORDS - 1);

    ////////////////////////////////////////
    // Frame sequencing
    ////////////////////////////////////////

    always_ff @(posedge USER_CLK) begin
        if (test_reset_i) begin
            state    <= serial_link_pkg::GEN_IDLE;
            word_cnt <= '0;
            lfsr     <= serial_link_pkg::LFSR_SEED;
        end else begin
            case (state)
                // One idle cycle after reset release
                serial_link_pkg::GEN_IDLE: begin
                    state <= serial_link_pkg::GEN_FRAME;
                end
                serial_link_pkg::GEN_FRAME: begin
                    // Advance only on an accepted word
                    if (valid_o && ready_i) begin
                        lfsr     <= serial_link_pkg::lfsr_next(lfsr);
                        word_cnt <= last_word ? '0 : word_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= serial_link_pkg::GEN_IDLE;
                end
            endcase
        end
    end

    // Word outputs follow the state, held while ready is low
    assign valid_o = state == serial_link_pkg::GEN_FRAME;
    assign data_o  = lfsr;
    assign sof_o   = valid_o && (word_cnt == '0);
    assign eof_o   = valid_o && last_word;

    // A stalled word stays put until taken
    a_hold_stalled : assert property (@(posedge USER_CLK) disable iff (test_reset_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o) && $stable(sof_o) &&
                                $stable(eof_o));

endmodule

// ==== src/link_lane_model.sv ====
/*
 * Behavioral stand-in for the multi-gigabit lane. Brings the lane and
 * channel up after reset, drops ready for clock compensation and
 * power-down, and returns accepted words LINK_LATENCY cycles later,
 * either through an internal pipeline or the word-wide serial ports.
 */
`timescale 1ns/1ps

module link_lane_model (
    input  logic                                USER_CLK,
    input  logic                                core_reset_i,
    input  logic                                power_down_i,
    input  serial_link_pkg::loop_mode_e         loop_mode_i,
    input  logic [serial_link_pkg::DATA_W-1:0]  tx_data_i,
    input  logic                                tx_valid_i,
    input  logic                                tx_sof_i,
    input  logic                                tx_eof_i,
    input  logic [serial_link_pkg::DATA_W-1:0]  ser_rx_data_i,
    input  logic                                ser_rx_valid_i,
    input  logic                                ser_rx_sof_i,
    input  logic                                ser_rx_eof_i,
    output logic                                tx_ready_o,
    output logic                                lane_up_o,
    output logic                                channel_up_o,
    output logic [serial_link_pkg::DATA_W-1:0]  rx_data_o,
    output logic                                rx_valid_o,
    output logic                                rx_sof_o,
    output logic                                rx_eof_o,
    output logic [serial_link_pkg::DATA_W-1:0]  ser_tx_data_o,
    output logic                                ser_tx_valid_o,
    output logic                                ser_tx_sof_o,
    output logic                                ser_tx_eof_o
);

    localparam int LAST = serial_link_pkg::LINK_LATENCY - 1;

    serial_link_pkg::lane_state_e               state;
    logic [serial_link_pkg::INIT_CNT_W-1:0]     init_cnt;
    logic [serial_link_pkg::CC_CNT_W-1:0]       cc_cnt;
    logic                                       cc_stall;
    logic                                       accept;
    logic                                       internal;
    logic [serial_link_pkg::DATA_W-1:0]         pipe_data [serial_link_pkg::LINK_LATENCY];
    logic [LAST:0]                              pipe_valid;
    logic [LAST:0]                              pipe_sof;
    logic [LAST:0]                              pipe_eof;

    ////////////////////////////////////////
    // Bring-up and power-down
    ////////////////////////////////////////

    always_ff @(posedge USER_CLK) begin
        if (core_reset_i || power_down_i) begin
            state    <= serial_link_pkg::LANE_DOWN;
            init_cnt <= '0;
        end else begin
            case (state)
                // Leaving DOWN counts as the first init cycle
                serial_link_pkg::LANE_DOWN: begin
                    state    <= serial_link_pkg::LANE_INIT;
                    init_cnt <= serial_link_pkg::INIT_CNT_W'(1);
                end
                serial_link_pkg::LANE_INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == serial_link_pkg::INIT_CNT_W'(
                                    serial_link_pkg::LANE_INIT_CYCLES - 1))
                        state <= serial_link_pkg::LANE_UP;
                end
                serial_link_pkg::LANE_UP: state <= serial_link_pkg::CHANNEL_UP;
                default: state <= serial_link_pkg::CHANNEL_UP;
            endcase
        end
    end

    assign lane_up_o    = state == serial_link_pkg::LANE_UP || state == serial_link_pkg::CHANNEL_UP;
    assign channel_up_o = state == serial_link_pkg::CHANNEL_UP;

    // Compensation window at the end of every period
    always_ff @(posedge USER_CLK) begin
        if (!channel_up_o || cc_cnt == serial_link_pkg::CC_CNT_W'(serial_link_pkg::CC_PERIOD - 1))
            cc_cnt <= '0;
        else
            cc_cnt <= cc_cnt + 1'b1;
    end

    assign cc_stall = cc_cnt >= serial_link_pkg::CC_CNT_W'(
                      serial_link_pkg::CC_PERIOD - serial_link_pkg::CC_LENGTH);
    assign tx_ready_o = channel_up_o && !cc_stall && !power_down_i;
    assign accept     = tx_valid_i && tx_ready_o;
    assign internal   = loop_mode_i != serial_link_pkg::LOOP_NONE;

    ////////////////////////////////////////
    // Loopback pipeline
    ////////////////////////////////////////

    always_ff @(posedge USER_CLK) begin
        // Control bits flush, payload just shifts
        if (core_reset_i || power_down_i)
            pipe_valid <= '0;
        else
            pipe_valid <= {pipe_valid[LAST-1:0], accept && internal};
        pipe_sof <= {pipe_sof[LAST-1:0], tx_sof_i};
        pipe_eof <= {pipe_eof[LAST-1:0], tx_eof_i};
        pipe_data[0] <= tx_data_i;
        for (int i = 1; i <= LAST; i++)
            pipe_data[i] <= pipe_data[i-1];
    end

    // Far end sees the accepted word directly
    assign ser_tx_data_o  = tx_data_i;
    assign ser_tx_valid_o = accept && !internal;
    assign ser_tx_sof_o   = tx_sof_i;
    assign ser_tx_eof_o   = tx_eof_i;

    // Receive side, serial words only on a live lane
    assign rx_data_o  = internal ? pipe_data[LAST] : ser_rx_data_i;
    assign rx_valid_o = internal ? pipe_valid[LAST] : ser_rx_valid_i && lane_up_o;
    assign rx_sof_o   = internal ? pipe_sof[LAST] : ser_rx_sof_i;
    assign rx_eof_o   = internal ? pipe_eof[LAST] : ser_rx_eof_i;

    // Looped words never outlive the lane
    a_rx_needs_lane : assert property (@(posedge USER_CLK) !lane_up_o |-> !rx_valid_o);

endmodule

// ==== src/frame_check.sv ====
/*
 * Receive-side checker. In test mode every received word is compared
 * with the generator's LFSR sequence and mismatches are counted. Framing
 * is watched in both modes, since the test reset is held outside tests.
 */
`timescale 1ns/1ps

module frame_check (
    input  logic                                USER_CLK,
    input  logic                                test_reset_i,
    input  logic [serial_link_pkg::DATA_W-1:0]  rx_data_i,
    input  logic                                rx_valid_i,
    input  logic                                rx_sof_i,
    input  logic                                rx_eof_i,
    output logic [serial_link_pkg::CNT_W-1:0]   error_count_o,
    output logic                                frame_error_o
);

    logic [serial_link_pkg::DATA_W-1:0]         expected;
    logic                                       mismatch;
    logic                                       in_frame = 1'b0;

    assign mismatch = rx_data_i != expected;

    ////////////////////////////////////////
    // Data check
    ////////////////////////////////////////

    always_ff @(posedge USER_CLK) begin
        if (test_reset_i) begin
            expected      <= serial_link_pkg::LFSR_SEED;
            error_count_o <= '0;
        end else if (rx_valid_i) begin
            if (mismatch) begin
                // Resync on the received word
                expected <= serial_link_pkg::lfsr_next(rx_data_i);
                if (error_count_o != '1)
                    error_count_o <= error_count_o + 1'b1;
            end else begin
                expected <= serial_link_pkg::lfsr_next(expected);
            end
        end
    end

    ////////////////////////////////////////
    // Framing
    ////////////////////////////////////////

    always_ff @(posedge USER_CLK) begin
        if (rx_valid_i) begin
            if (rx_eof_i)
                in_frame <= 1'b0;
            else if (rx_sof_i)
                in_frame <= 1'b1;
        end
    end

    // Sof inside a frame, or a stray word outside one
    always_ff @(posedge USER_CLK) begin
        frame_error_o <= rx_valid_i && (rx_sof_i ? in_frame : !in_frame);
    end

    // Count only climbs or saturates between test resets
    a_count_monotonic : assert property (@(posedge USER_CLK) disable iff (test_reset_i)
        !$past(test_reset_i) |-> error_count_o >= $past(error_count_o));

endmodule

// ==== src/link_status.sv ====
/*
 * Status register and frame strobes. Status bits are registered
 * with frame error held until reset; sent and received pulses come
 * from rising edges of the accepted eof strobes.
 */
`timescale 1ns/1ps

module link_status (
    input  logic                                USER_CLK,
    input  logic                                RESET_IN,
    input  logic                                lane_up_i,
    input  logic                                channel_up_i,
    input  logic                                frame_error_i,
    input  logic                                tx_accept_eof_i,
    input  logic                                rx_eof_i,
    output logic [serial_link_pkg::STAT_W-1:0]  stat_o,
    output logic                                frame_sent_o,
    output logic                                frame_rcvd_o
);

    logic   tx_eof_q;
    logic   rx_eof_q;

    always_ff @(posedge USER_CLK) begin
        if (RESET_IN) begin
            stat_o       <= '0;
            frame_sent_o <= 1'b0;
            frame_rcvd_o <= 1'b0;
            tx_eof_q     <= 1'b0;
            rx_eof_q     <= 1'b0;
        end else begin
            // Channel up, lane up, sticky frame error
            stat_o       <= {channel_up_i, lane_up_i, stat_o[0] | frame_error_i};
            frame_sent_o <= tx_accept_eof_i && !tx_eof_q;
            frame_rcvd_o <= rx_eof_i && !rx_eof_q;
            tx_eof_q     <= tx_accept_eof_i;
            rx_eof_q     <= rx_eof_i;
        end
    end

endmodule

// ==== src/serial_link_top.sv ====
/*
 * Serial link user-side wrapper. Connects control decode, test frame
 * generator, lane model, frame checker and status block to the user
 * ports and to the word-wide serial-side ports used with LOOP_NONE.
 */
`timescale 1ns/1ps

module serial_link_top (
    input  logic                                USER_CLK,
    input  logic                                RESET_IN,
    input  logic [serial_link_pkg::CTRL_W-1:0]  ctrl_reg_i,
    input  logic [serial_link_pkg::DATA_W-1:0]  tx_data_i,
    input  logic                                tx_valid_i,
    input  logic                                tx_sof_i,
    input  logic                                tx_eof_i,
    input  logic [serial_link_pkg::DATA_W-1:0]  ser_rx_data_i,
    input  logic                                ser_rx_valid_i,
    input  logic                                ser_rx_sof_i,
    input  logic                                ser_rx_eof_i,
    output logic                                tx_ready_o,
    output logic [serial_link_pkg::DATA_W-1:0]  rx_data_o,
    output logic                                rx_valid_o,
    output logic                                rx_sof_o,
    output logic                                rx_eof_o,
    output logic [serial_link_pkg::DATA_W-1:0]  ser_tx_data_o,
    output logic                                ser_tx_valid_o,
    output logic                                ser_tx_sof_o,
    output logic                                ser_tx_eof_o,
    output logic [serial_link_pkg::STAT_W-1:0]  stat_o,
    output logic                                frame_sent_o,
    output logic                                frame_rcvd_o,
    output logic [serial_link_pkg::CNT_W-1:0]   error_count_o
);

    logic                                       core_reset;
    logic                                       test_reset;
    logic                                       power_down;
    serial_link_pkg::loop_mode_e                loop_mode;
    logic                                       lane_up;
    logic                                       channel_up;
    logic                                       frame_error;

    // Generator group and muxed lane transmit group
    logic [serial_link_pkg::DATA_W-1:0]         gen_data;
    logic                                       gen_valid;
    logic                                       gen_sof;
    logic                                       gen_eof;
    logic [serial_link_pkg::DATA_W-1:0]         lane_tx_data;
    logic                                       lane_tx_valid;
    logic                                       lane_tx_sof;
    logic                                       lane_tx_eof;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    link_ctrl_decode u_decode (
        .USER_CLK     (USER_CLK),
        .RESET_IN     (RESET_IN),
        .ctrl_reg_i   (ctrl_reg_i),
        .lane_up_i    (lane_up),
        .user_data_i  (tx_data_i),
        .user_valid_i (tx_valid_i),
        .user_sof_i   (tx_sof_i),
        .user_eof_i   (tx_eof_i),
        .gen_data_i   (gen_data),
        .gen_valid_i  (gen_valid),
        .gen_sof_i    (gen_sof),
        .gen_eof_i    (gen_eof),
        .core_reset_o (core_reset),
        .test_reset_o (test_reset),
        .test_mode_o  (),
        .power_down_o (power_down),
        .loop_mode_o  (loop_mode),
        .tx_data_o    (lane_tx_data),
        .tx_valid_o   (lane_tx_valid),
        .tx_sof_o     (lane_tx_sof),
        .tx_eof_o     (lane_tx_eof)
    );

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    frame_gen u_gen (
        .USER_CLK     (USER_CLK),
        .test_reset_i (test_reset),
        .ready_i      (tx_ready_o),
        .data_o       (gen_data),
        .valid_o      (gen_valid),
        .sof_o        (gen_sof),
        .eof_o        (gen_eof)
    );

    link_lane_model u_lane (
        .USER_CLK       (USER_CLK),
        .core_reset_i   (core_reset),
        .power_down_i   (power_down),
        .loop_mode_i    (loop_mode),
        .tx_data_i      (lane_tx_data),
        .tx_valid_i     (lane_tx_valid),
        .tx_sof_i       (lane_tx_sof),
        .tx_eof_i       (lane_tx_eof),
        .ser_rx_data_i  (ser_rx_data_i),
        .ser_rx_valid_i (ser_rx_valid_i),
        .ser_rx_sof_i   (ser_rx_sof_i),
        .ser_rx_eof_i   (ser_rx_eof_i),
        .tx_ready_o     (tx_ready_o),
        .lane_up_o      (lane_up),
        .channel_up_o   (channel_up),
        .rx_data_o      (rx_data_o),
        .rx_valid_o     (rx_valid_o),
        .rx_sof_o       (rx_sof_o),
        .rx_eof_o       (rx_eof_o),
        .ser_tx_data_o  (ser_tx_data_o),
        .ser_tx_valid_o (ser_tx_valid_o),
        .ser_tx_sof_o   (ser_tx_sof_o),
        .ser_tx_eof_o   (ser_tx_eof_o)
    );

    ////////////////////////////////////////
    // Result
    ////////////////////////////////////////

    frame_check u_check (
        .USER_CLK      (USER_CLK),
        .test_reset_i  (test_reset),
        .rx_data_i     (rx_data_o),
        .rx_valid_i    (rx_valid_o),
        .rx_sof_i      (rx_sof_o),
        .rx_eof_i      (rx_eof_o),
        .error_count_o (error_count_o),
        .frame_error_o (frame_error)
    );

    // Eof strobes count only accepted or valid words
    link_status u_status (
        .USER_CLK        (USER_CLK),
        .RESET_IN        (RESET_IN),
        .lane_up_i       (lane_up),
        .channel_up_i    (channel_up),
        .frame_error_i   (frame_error),
        .tx_accept_eof_i (lane_tx_valid && tx_ready_o && lane_tx_eof),
        .rx_eof_i        (rx_valid_o && rx_eof_o),
        .stat_o          (stat_o),
        .frame_sent_o    (frame_sent_o),
        .frame_rcvd_o    (frame_rcvd_o)
    );

endmodule

// ==== tb/tb_serial_link.sv ====
/*
 * Self-checking testbench for the serial link wrapper. Checks bring-up
 * timing, then applies a table of normal and test mode runs. It acts as
 * the far end in LOOP_NONE, and finishes with framing fault and
 * power-down checks.
 */
`timescale 1ns/1ps

module tb_serial_link;

    localparam int LAT  = serial_link_pkg::LINK_LATENCY;
    localparam int FW   = serial_link_pkg::FRAME_WORDS;
    localparam int NTBL = 5;
    localparam logic [15:0] FLIP = 16'h0100;

    logic USER_CLK = 1'b0;
    logic RESET_IN;
    logic [serial_link_pkg::CTRL_W-1:0] ctrl_reg_i;
    logic [15:0] tx_data_i, ser_rx_data_i;
    logic tx_valid_i, tx_sof_i, tx_eof_i;
    logic ser_rx_valid_i, ser_rx_sof_i, ser_rx_eof_i;
    logic tx_ready_o, rx_valid_o, rx_sof_o, rx_eof_o;
    logic ser_tx_valid_o, ser_tx_sof_o, ser_tx_eof_o;
    logic [15:0] rx_data_o, ser_tx_data_o, error_count_o;
    logic [serial_link_pkg::STAT_W-1:0] stat_o;
    logic frame_sent_o, frame_rcvd_o;

    // Stimulus table, one run per row
    logic [serial_link_pkg::CTRL_W-1:0] tbl_ctrl [NTBL];
    int tbl_frames [NTBL];
    int tbl_corrupt [NTBL];

    // Words to send and expected receive stream
    logic [15:0] buf_data [256];
    logic buf_sof [256];
    logic buf_eof [256];
    logic [17:0] exp_q [$];
    int exp_time [$];

    logic [31:0] lcg_state = 32'd22594;
    logic [15:0] ref_lfsr;
    logic [18:0] fe_cap;
    logic [18:0] fe_line [LAT-1];
    logic accepted;
    int cycle, chk_mode, rx_words, fe_words, corrupt_idx;
    int sent_pulses, rcvd_pulses, fail_count, n;

    serial_link_top dut0 (.*);

    always #5 USER_CLK = ~USER_CLK;

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] x);
        return {x[14:0], x[15] ^ x[13] ^ x[12] ^ x[10]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_count++;
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic report_error(input string what);
        fail_count++;
        $display("Error: %s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // Far end, LINK_LATENCY word delay
    ////////////////////////////////////////

    always @(negedge USER_CLK) begin
        fe_cap = '0;
        if (ser_tx_valid_o) begin
            fe_cap = {1'b1, ser_tx_sof_o, ser_tx_eof_o,
                      ser_tx_data_o ^ ((fe_words == corrupt_idx) ? FLIP : 16'h0)};
            fe_words++;
        end
    end

    always @(posedge USER_CLK) begin
        fe_line[0] <= fe_cap;
        for (int i = 1; i < LAT - 1; i++)
            fe_line[i] <= fe_line[i-1];
        {ser_rx_valid_i, ser_rx_sof_i, ser_rx_eof_i, ser_rx_data_i} <= fe_line[LAT-2];
    end

    ////////////////////////////////////////
    // Monitor, samples between edges
    ////////////////////////////////////////

    always @(negedge USER_CLK) begin
        cycle++;
        accepted = tx_valid_i && tx_ready_o;
        if (chk_mode == 1 && accepted) begin
            exp_q.push_back({tx_sof_i, tx_eof_i, tx_data_i});
            exp_time.push_back(cycle);
        end
        if (chk_mode != 0 && rx_valid_o) begin
            if (chk_mode == 1) begin
                if (exp_q.size() == 0)
                    report_error("received a word that was never sent");
                check_value("rx_data_o", rx_data_o, exp_q[0][15:0]);
                check_value("rx_sof_o", rx_sof_o, exp_q[0][17]);
                check_value("rx_eof_o", rx_eof_o, exp_q[0][16]);
                check_value("rx latency", cycle - exp_time[0], LAT);
                void'(exp_q.pop_front());
                void'(exp_time.pop_front());
            end else begin
                // Corrupted word carries the far-end flip
                check_value("rx_data_o", rx_data_o,
                            ref_lfsr ^ ((rx_words == corrupt_idx) ? FLIP : 16'h0));
                ref_lfsr = lfsr_step(ref_lfsr);
            end
            rx_words++;
        end
        if (chk_mode != 0 && frame_sent_o)
            sent_pulses++;
        if (chk_mode != 0 && frame_rcvd_o)
            rcvd_pulses++;
    end

    // Sends buf words in order, holding each until accepted
    task automatic send_words(input int total);
        int w;
        w = 0;
        @(posedge USER_CLK);
        {tx_valid_i, tx_sof_i, tx_eof_i, tx_data_i} <= {1'b1, buf_sof[0], buf_eof[0], buf_data[0]};
        while (w < total) begin
            @(posedge USER_CLK);
            if (accepted)
                w++;
            if (w < total)
                {tx_valid_i, tx_sof_i, tx_eof_i, tx_data_i} <=
                    {1'b1, buf_sof[w], buf_eof[w], buf_data[w]};
            else
                tx_valid_i <= 1'b0;
        end
    endtask

    task automatic start_run(input logic [serial_link_pkg::CTRL_W-1:0] ctrl,
                             input int mode, input int corrupt);
        @(posedge USER_CLK);
        corrupt_idx = corrupt;
        fe_words    = 0;
        rx_words    = 0;
        sent_pulses = 0;
        rcvd_pulses = 0;
        ref_lfsr    = serial_link_pkg::LFSR_SEED;
        chk_mode    = mode;
        ctrl_reg_i <= ctrl;
        // Control fields settle before traffic
        repeat (2) @(posedge USER_CLK);
    endtask

    task automatic run_entry(input int idx);
        int total;
        logic test;
        test  = tbl_ctrl[idx][serial_link_pkg::CTRL_TEST_BIT];
        total = tbl_frames[idx] * FW;
        start_run(tbl_ctrl[idx], test ? 2 : 1, tbl_corrupt[idx]);
        if (!test) begin
            for (int i = 0; i < total; i++) begin
                buf_data[i] = lcg_next();
                buf_sof[i]  = (i % FW) == 0;
                buf_eof[i]  = (i % FW) == FW - 1;
            end
            send_words(total);
        end
        // Monitor counters move on falling edges, read them on rising ones
        while (rx_words < total)
            @(posedge USER_CLK);
        repeat (2) @(posedge USER_CLK);
        check_value("frame_rcvd_o count", rcvd_pulses, tbl_frames[idx]);
        if (!test) begin
            check_value("frame_sent_o count", sent_pulses, tbl_frames[idx]);
            check_value("pending words", exp_q.size(), 0);
        end else begin
            @(negedge USER_CLK);
            check_value("error_count_o", error_count_o, tbl_corrupt[idx] >= 0 ? 2 : 0);
            repeat (FW) @(negedge USER_CLK);
            check_value("error_count_o", error_count_o, tbl_corrupt[idx] >= 0 ? 2 : 0);
        end
        // Back to idle normal mode and drain the lane
        @(posedge USER_CLK);
        chk_mode = 0;
        ctrl_reg_i <= 11'h004;
        repeat (2 * LAT + 4) @(posedge USER_CLK);
    endtask

    // Watchdog sized from the table
    initial begin
        int limit;
        #1;
        limit = 0;
        for (int i = 0; i < NTBL; i++)
            limit += tbl_frames[i] * (FW + serial_link_pkg::CC_LENGTH);
        limit += (NTBL + 3) * (16 + serial_link_pkg::RESET_STRETCH +
                               serial_link_pkg::LANE_INIT_CYCLES + 2 * LAT + 10);
        repeat (2 * limit) @(posedge USER_CLK);
        $display("Timeout: the run did not finish in time");
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        // Rows are near loop normal, serial normal, test near, test serial, corrupted
        tbl_ctrl[0]    = 11'h004;
        tbl_frames[0]  = 10;
        tbl_corrupt[0] = -1;
        tbl_ctrl[1]    = 11'h000;
        tbl_frames[1]  = 3;
        tbl_corrupt[1] = -1;
        tbl_ctrl[2]    = 11'h006;
        tbl_frames[2]  = 4;
        tbl_corrupt[2] = -1;
        tbl_ctrl[3]    = 11'h002;
        tbl_frames[3]  = 4;
        tbl_corrupt[3] = -1;
        tbl_ctrl[4]    = 11'h002;
        tbl_frames[4]  = 3;
        tbl_corrupt[4] = 5;
        for (int i = 0; i < LAT - 1; i++)
            fe_line[i] = '0;
        fe_cap = '0;
        RESET_IN = 1'b1;
        ctrl_reg_i = '0;
        {tx_valid_i, tx_sof_i, tx_eof_i, tx_data_i} = '0;
        {ser_rx_valid_i, ser_rx_sof_i, ser_rx_eof_i, ser_rx_data_i} = '0;
        cycle       = 0;
        chk_mode    = 0;
        rx_words    = 0;
        fe_words    = 0;
        corrupt_idx = -1;
        fail_count  = 0;
        accepted    = 1'b0;

        // Bring-up
        repeat (16) @(posedge USER_CLK);
        @(negedge USER_CLK);
        check_value("outputs in reset", {tx_ready_o, rx_valid_o, ser_tx_valid_o, stat_o,
                    frame_sent_o, frame_rcvd_o, error_count_o}, 0);
        @(posedge USER_CLK);
        RESET_IN <= 1'b0;
        n = 0;
        do begin
            @(posedge USER_CLK);
            n++;
            @(negedge USER_CLK);
        end while (!stat_o[1]);
        check_value("lane up delay", n,
                    serial_link_pkg::RESET_STRETCH + serial_link_pkg::LANE_INIT_CYCLES + 1);
        check_value("stat_o channel up", stat_o[2], 0);
        @(negedge USER_CLK);
        check_value("stat_o channel up", stat_o[2], 1);
        check_value("stat_o frame error", stat_o[0], 0);

        // Sof twice without eof, then close the frame
        start_run(11'h004, 1, -1);
        buf_data[0] = 16'h1111;
        buf_sof[0]  = 1'b1;
        buf_eof[0]  = 1'b0;
        buf_data[1] = 16'h2222;
        buf_sof[1]  = 1'b1;
        buf_eof[1]  = 1'b0;
        buf_data[2] = 16'h3333;
        buf_sof[2]  = 1'b0;
        buf_eof[2]  = 1'b1;
        send_words(3);
        while (rx_words < 3)
            @(negedge USER_CLK);
        repeat (2) @(negedge USER_CLK);
        check_value("stat_o frame error", stat_o[0], 1);
        chk_mode = 0;

        for (int i = 0; i < NTBL; i++)
            run_entry(i);

        // Power-down and recovery
        @(posedge USER_CLK);
        ctrl_reg_i <= 11'h014;
        do @(negedge USER_CLK); while (stat_o[1]);
        check_value("tx_ready_o", tx_ready_o, 0);
        @(posedge USER_CLK);
        ctrl_reg_i <= 11'h004;
        n = 0;
        do begin
            @(posedge USER_CLK);
            n++;
            @(negedge USER_CLK);
        end while (!stat_o[1]);
        check_value("lane up after power-down", n, serial_link_pkg::LANE_INIT_CYCLES + 2);

        if (fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== build.f ====
src/serial_link_pkg.sv
src/link_ctrl_decode.sv
src/frame_gen.sv
src/link_lane_model.sv
src/frame_check.sv
src/link_status.sv
src/serial_link_top.sv
tb/tb_serial_link.sv
